// File: src.f
verilog/busPkg.sv
verilog/tStateCounter.sv
verilog/cycleSequencer.sv
verilog/pinControl.sv
verilog/padLatches.sv
verilog/busInterface.sv
verif/clockGen.sv
verif/busInterface_assertions.sv
verif/busInterfaceTb.sv

// File: verif/busInterfaceTb.sv
//----------------------------------------------------------
// Bus interface testbench
// Random machine cycles checked against a cycle level model
//----------------------------------------------------------
`timescale 1ns/1ps

module busInterfaceTb import busPkg::*; ();

    localparam int NumCycles    = 300;
    localparam int TimeoutLimit = NumCycles * 12 + 200;

    typedef enum logic [1:0] {mIdle, mRun, mHold, mGranted} modelState_e;

    logic        setM1;
    logic        rstN;
    logic        start;
    cycleKind_e  kind;
    logic [15:0] addr;
    logic [7:0]  wrData;
    logic        memWait;
    logic        busReq;
    logic [7:0]  dataPins;
    logic        m1;
    logic        mreq;
    logic        iorq;
    logic        rd;
    logic        wr;
    logic        rfsh;
    logic        busAck;
    logic        ctrlOe;
    logic        addrOe;
    logic [15:0] addrPins;
    logic [7:0]  dataOut;
    logic        dataOe;
    logic        busy;
    logic        done;
    logic [7:0]  rdData;

    // Model state updated at every rising edge
    modelState_e mState;
    cycleKind_e  mKind;
    tState_e     mT;
    int          mIdx;
    logic [15:0] mAddrHold;
    logic [7:0]  mWrData;
    logic [7:0]  mRdData;
    logic [6:0]  mRfsh;
    logic        mDone;
    logic        mOeReady;
    int          edgesRun;
    int          heldW;
    // Run bookkeeping
    logic [31:0] rngState;
    int          reqLeft;
    int          edgeCount;
    int          doneCount;
    int          errorCount;
    int          timeoutCount;
    logic [6:0]  lastPins;
    logic [15:0] lastAddr;

    clockGen u_clockGen (
        .setM1 (setM1),
        .rstN  (rstN)
    );

    busInterface u_dut (.*);

    //----------------------------------------------------------
    // Reference rules
    //----------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int orderLen(input cycleKind_e k);
        case (k)
            kMemRead, kMemWrite: return 3;
            kIntAck:             return 6;
            default:             return 4;
        endcase
    endfunction

    // T-state at position idx of the kind's order
    function automatic tState_e orderState(input cycleKind_e k, input int idx);
        tState_e order [6];
        if (k == kIntAck) begin
            order = '{tT1, tT2, tTw1, tTw2, tT3, tT4};
        end else begin
            order = '{tT1, tT2, tT3, tT4, tIdle, tIdle};
        end
        return order[idx];
    endfunction

    function automatic tState_e waitState(input cycleKind_e k);
        case (k)
            kIoRead, kIoWrite: return tT3;
            kIntAck:           return tTw2;
            default:           return tT2;
        endcase
    endfunction

    // Write kinds capture nothing
    function automatic tState_e captureState(input cycleKind_e k);
        case (k)
            kFetch:   return tT2;
            kMemRead: return tT3;
            kIoRead:  return tT4;
            kIntAck:  return tTw2;
            default:  return tIdle;
        endcase
    endfunction

    // Start edge to the edge that samples done with no waits
    function automatic int latencyOf(input cycleKind_e k);
        case (k)
            kMemRead, kMemWrite: return 4;
            kIntAck:             return 7;
            default:             return 5;
        endcase
    endfunction

    function automatic logic inRange(input tState_e t, input tState_e lo, input tState_e hi);
        return (t >= lo) && (t <= hi);
    endfunction

    // Pin table as {m1, mreq, iorq, rd, wr, rfsh, dataOe}
    function automatic logic [6:0] expectPins(input cycleKind_e k, input tState_e t);
        logic [6:0] p;
        p = '0;
        case (k)
            kFetch: begin
                p[6] = inRange(t, tT1, tT2);
                p[5] = inRange(t, tT1, tT4);
                p[3] = inRange(t, tT1, tT2);
                p[1] = inRange(t, tT3, tT4);
            end
            kMemRead: begin
                p[5] = inRange(t, tT1, tT3);
                p[3] = inRange(t, tT1, tT3);
            end
            kMemWrite: begin
                p[5] = inRange(t, tT1, tT3);
                p[2] = inRange(t, tT2, tT3);
                p[0] = inRange(t, tT1, tT3);
            end
            kIoRead: begin
                p[4] = inRange(t, tT2, tT4);
                p[3] = inRange(t, tT2, tT4);
            end
            kIoWrite: begin
                p[4] = inRange(t, tT2, tT4);
                p[2] = inRange(t, tT2, tT4);
                p[0] = inRange(t, tT1, tT4);
            end
            default: begin
                p[6] = inRange(t, tT1, tTw2);
                p[4] = inRange(t, tTw1, tTw2);
                p[5] = inRange(t, tT3, tT4);
                p[1] = inRange(t, tT3, tT4);
            end
        endcase
        return p;
    endfunction

    //----------------------------------------------------------
    // Reporting
    //----------------------------------------------------------
    task automatic failRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp) else begin
            failRun($sformatf("** Error: %s is 0x%0h, expected 0x%0h at %0t",
                              name, got, exp, $time));
        end
    endtask

    //----------------------------------------------------------
    // Model step and stimulus
    //----------------------------------------------------------
    // Inputs are read before this edge's updates land
    always @(posedge setM1) begin : modelStep
        logic [31:0] r;
        logic [31:0] r2;
        logic        isLast;
        edgeCount++;
        if (!rstN) begin
            mState   = mIdle;
            mT       = tIdle;
            mRfsh    = '0;
            mDone    = 1'b0;
            mOeReady = 1'b0;
        end else begin
            isLast = (mIdx == orderLen(mKind) - 1);
            // Edges since the last accepted start
            edgesRun++;
            if (start) begin
                mAddrHold = addr;
                mWrData   = wrData;
            end
            // Held capture state keeps overwriting so the last cycle wins
            if (mT != tIdle && mT == captureState(mKind)) begin
                mRdData = dataPins;
            end
            if (mT == tT3 && (mKind == kFetch || mKind == kIntAck)) begin
                mRfsh = mRfsh + 7'd1;
            end
            mDone    = 1'b0;
            mOeReady = 1'b1;
            case (mState)
                mIdle: begin
                    if (busReq) begin
                        mState = mGranted;
                    end else if (start) begin
                        mState   = mRun;
                        mKind    = kind;
                        mIdx     = 0;
                        edgesRun = 0;
                        heldW    = 0;
                    end
                end
                mGranted: begin
                    if (!busReq) begin
                        mState = mIdle;
                    end
                end
                default: begin
                    if (mState == mRun && isLast) begin
                        mDone  = 1'b1;
                        mState = busReq ? mGranted : mIdle;
                    end else if (mT == waitState(mKind) && memWait) begin
                        mState = mHold;
                        heldW++;
                    end else begin
                        mState = mRun;
                        mIdx++;
                    end
                end
            endcase
        end
        mT = (mState == mRun || mState == mHold) ? orderState(mKind, mIdx) : tIdle;

        r        = xorshift32(rngState);
        r2       = xorshift32(r);
        rngState = r2;
        if (!rstN) begin
            start   <= 1'b0;
            busReq  <= 1'b0;
            memWait <= 1'b0;
        end else begin
            // start only when the DUT is idle in the coming cycle
            start    <= (mState == mIdle) && (r[1:0] != 2'd0);
            kind     <= cycleKind_e'(r[4:2] % 3'd6);
            addr     <= r[20:5];
            wrData   <= r[28:21];
            memWait  <= (r[31:30] == 2'd0);
            dataPins <= r2[7:0];
            // Occasional bursts of 1 to 4 cycles
            if (reqLeft > 0) begin
                busReq <= 1'b1;
                reqLeft--;
            end else if (r2[12:8] == 5'd0) begin
                busReq <= 1'b1;
                reqLeft = r2[14:13];
            end else begin
                busReq <= 1'b0;
            end
        end
    end

    //----------------------------------------------------------
    // Checks at mid cycle where outputs are settled
    //----------------------------------------------------------
    always @(negedge setM1) begin : checkStep
        logic [6:0] pins;
        logic [6:0] exp;
        busAddr_u   expAddr;
        if (edgeCount > 0) begin
            exp  = expectPins(mKind, mT);
            pins = {m1, mreq, iorq, rd, wr, rfsh, dataOe};
            checkValue("m1", m1, exp[6]);
            checkValue("mreq", mreq, exp[5]);
            checkValue("iorq", iorq, exp[4]);
            checkValue("rd", rd, exp[3]);
            checkValue("wr", wr, exp[2]);
            checkValue("rfsh", rfsh, exp[1]);
            checkValue("dataOe", dataOe, exp[0]);
            checkValue("busAck", busAck, mState == mGranted);
            checkValue("busy", busy, mState != mIdle);
            // Latency rule applied where the DUT itself signals done
            if (done === 1'b1) begin
                checkValue("latency", edgesRun + 1, latencyOf(mKind) + heldW);
            end
            checkValue("done", done, mDone);
            checkValue("ctrlOe", ctrlOe, mOeReady && mState != mGranted);
            checkValue("addrOe", addrOe, mOeReady && mState != mGranted);
            if (mT != tIdle) begin
                // Refresh slot shows the count and T4 keeps the pre-increment value
                if (inRange(mT, tT3, tT4) && (mKind == kFetch || mKind == kIntAck)) begin
                    expAddr.rfshView.fill      = '0;
                    expAddr.rfshView.rfshCount = (mT == tT3) ? mRfsh : mRfsh - 7'd1;
                end else begin
                    expAddr.addr = mAddrHold;
                end
                checkValue("addrPins", addrPins, expAddr.addr);
            end
            if (exp[0]) begin
                checkValue("dataOut", dataOut, mWrData);
            end
            if (mState == mHold) begin
                checkValue("pins during hold", pins, lastPins);
                checkValue("addrPins during hold", addrPins, lastAddr);
            end
            if (mDone) begin
                doneCount++;
                if (captureState(mKind) != tIdle) begin
                    checkValue("rdData", rdData, mRdData);
                end
            end
            lastPins = pins;
            lastAddr = addrPins;
        end
    end

    // Hard limit on clock cycles
    always @(posedge setM1) begin
        timeoutCount++;
        if (timeoutCount >= TimeoutLimit) begin
            failRun("Timeout, the machine cycles did not all complete in time");
        end
    end

    //----------------------------------------------------------
    // Run control
    //----------------------------------------------------------
    initial begin
        start        = 1'b0;
        kind         = kFetch;
        addr         = '0;
        wrData       = '0;
        memWait      = 1'b0;
        busReq       = 1'b0;
        dataPins     = '0;
        rngState     = 32'd60;
        reqLeft      = 0;
        edgeCount    = 0;
        doneCount    = 0;
        errorCount   = 0;
        timeoutCount = 0;
        mState       = mIdle;
        mKind        = kFetch;
        mT           = tIdle;
        mIdx         = 0;
        mRfsh        = '0;
        mDone        = 1'b0;
        mOeReady     = 1'b0;
        edgesRun     = 0;
        heldW        = 0;
        // First cycle after reset
        @(posedge rstN);
        @(posedge setM1);
        @(negedge setM1);
        checkValue("status after reset", {m1, mreq, iorq, rd, wr, rfsh,
                   dataOe, busAck, busy, done}, 16'h0);
        checkValue("ctrlOe after reset", ctrlOe, 1'b1);
        checkValue("addrOe after reset", addrOe, 1'b1);
        wait (doneCount >= NumCycles);
        @(negedge setM1);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            failRun("Errors were recorded during the run");
        end
    end

endmodule

// File: verif/busInterface_assertions.sv
//----------------------------------------------------------
// Bus interface protocol assertions
// Bound into every busInterface instance
//----------------------------------------------------------
`timescale 1ns/1ps

module busInterfaceAssertions (
    input logic setM1,
    input logic rstN,
    input logic rd,
    input logic wr,
    input logic mreq,
    input logic rfsh,
    input logic done,
    input logic busAck,
    input logic ctrlOe,
    input logic addrOe
);

    // Read and write strobes never overlap
    rdWrExclusive: assert property (@(posedge setM1) disable iff (!rstN) !(rd && wr))
        else $error("rd and wr are high together");

    // Completion is a single cycle pulse
    donePulse: assert property (@(posedge setM1) disable iff (!rstN) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Granted bus means our drivers are off
    grantOff: assert property (@(posedge setM1) disable iff (!rstN)
        busAck |-> (!ctrlOe && !addrOe))
        else $error("output enables high while busAck is high");

    // Refresh address is always strobed by mreq
    rfshMreq: assert property (@(posedge setM1) disable iff (!rstN) rfsh |-> mreq)
        else $error("rfsh high without mreq");

endmodule

bind busInterface busInterfaceAssertions u_assertions (
    .setM1  (setM1),
    .rstN   (rstN),
    .rd     (rd),
    .wr     (wr),
    .mreq   (mreq),
    .rfsh   (rfsh),
    .done   (done),
    .busAck (busAck),
    .ctrlOe (ctrlOe),
    .addrOe (addrOe)
);

// File: verif/clockGen.sv
//----------------------------------------------------------
// Testbench clock and reset generator
//----------------------------------------------------------
`timescale 1ns/1ps

module clockGen (
    output logic setM1,
    output logic rstN
);

    // 100 ns period
    initial begin
        setM1 = 1'b0;
        forever #50 setM1 = ~setM1;
    end

    // Reset seen low at the first three rising edges
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge setM1);
        rstN <= 1'b1;
    end

endmodule

// File: verilog/busInterface.sv
//----------------------------------------------------------
// Bus interface unit
// Top level of the Z80 style machine cycle engine
//----------------------------------------------------------
`timescale 1ns/1ps

module busInterface import busPkg::*; (
    input  logic        setM1,
    input  logic        rstN,
    // Cycle request
    input  logic        start,
    input  cycleKind_e  kind,
    input  logic [15:0] addr,
    input  logic [7:0]  wrData,
    // Bus side inputs
    input  logic        memWait,
    input  logic        busReq,
    input  logic [7:0]  dataPins,
    // Control pins
    output logic        m1,
    output logic        mreq,
    output logic        iorq,
    output logic        rd,
    output logic        wr,
    output logic        rfsh,
    // Bus control
    output logic        busAck,
    output logic        ctrlOe,
    output logic        addrOe,
    // Address and data pads
    output logic [15:0] addrPins,
    output logic [7:0]  dataOut,
    output logic        dataOe,
    // Status
    output logic        busy,
    output logic        done,
    output logic [7:0]  rdData
);

    cycleKind_e curKind;
    tState_e    tState;
    logic       advance;
    logic       clear;
    logic       lastT;
    logic       waitPoint;
    logic       loadAddr;
    logic       loadRfsh;
    logic       captureData;

    //----------------------------------------------------------
    // Sequencing
    //----------------------------------------------------------
    tStateCounter u_tStateCounter (
        .setM1   (setM1),
        .rstN    (rstN),
        .advance (advance),
        .clear   (clear),
        .kind    (curKind),
        .tState  (tState),
        .lastT   (lastT)
    );

    cycleSequencer u_cycleSequencer (
        .setM1     (setM1),
        .rstN      (rstN),
        .start     (start),
        .kind      (kind),
        .busReq    (busReq),
        .memWait   (memWait),
        .waitPoint (waitPoint),
        .tState    (tState),
        .lastT     (lastT),
        .curKind   (curKind),
        .advance   (advance),
        .clear     (clear),
        .busAck    (busAck),
        .busy      (busy),
        .done      (done)
    );

    //----------------------------------------------------------
    // Pads
    //----------------------------------------------------------
    pinControl u_pinControl (
        .setM1       (setM1),
        .rstN        (rstN),
        .tState      (tState),
        .curKind     (curKind),
        .busAck      (busAck),
        .m1          (m1),
        .mreq        (mreq),
        .iorq        (iorq),
        .rd          (rd),
        .wr          (wr),
        .rfsh        (rfsh),
        .ctrlOe      (ctrlOe),
        .addrOe      (addrOe),
        .dataOe      (dataOe),
        .waitPoint   (waitPoint),
        .loadAddr    (loadAddr),
        .loadRfsh    (loadRfsh),
        .captureData (captureData)
    );

    padLatches u_padLatches (
        .setM1       (setM1),
        .rstN        (rstN),
        .start       (start),
        .addr        (addr),
        .wrData      (wrData),
        .dataPins    (dataPins),
        .loadAddr    (loadAddr),
        .loadRfsh    (loadRfsh),
        .captureData (captureData),
        .curKind     (curKind),
        .addrPins    (addrPins),
        .dataOut     (dataOut),
        .rdData      (rdData)
    );

endmodule

// File: verilog/busPkg.sv
//----------------------------------------------------------
// Bus interface package
// Cycle kinds, T-states and the address pad word
//----------------------------------------------------------
package busPkg;

    //----------------------------------------------------------
    // Machine cycle kinds, supplied from outside with start
    //----------------------------------------------------------
    typedef enum logic [2:0] {
        kFetch    = 3'd0,
        kMemRead  = 3'd1,
        kMemWrite = 3'd2,
        kIoRead   = 3'd3,
        kIoWrite  = 3'd4,
        kIntAck   = 3'd5
    } cycleKind_e;

    //----------------------------------------------------------
    // T-states of one machine cycle
    //----------------------------------------------------------
    // Tw1 and Tw2 are the automatic waits of interrupt acknowledge
    typedef enum logic [2:0] {
        tIdle = 3'd0,
        tT1   = 3'd1,
        tT2   = 3'd2,
        tTw1  = 3'd3,
        tTw2  = 3'd4,
        tT3   = 3'd5,
        tT4   = 3'd6
    } tState_e;

    //----------------------------------------------------------
    // Address pad word
    //----------------------------------------------------------
    // Plain memory or I/O address
    // Or the refresh view shown during the refresh slots
    typedef union packed {
        logic [15:0] addr;
        struct packed {
            // Upper byte and bit 7 stay zero, no I register here
            logic [8:0] fill;
            logic [6:0] rfshCount;
        } rfshView;
    } busAddr_u;

endpackage

// File: verilog/cycleSequencer.sv
//----------------------------------------------------------
// Cycle sequencer
// Runs one machine cycle per start, inserts waits, grants the bus
//----------------------------------------------------------
`timescale 1ns/1ps

module cycleSequencer import busPkg::*; (
    input  logic       setM1,
    input  logic       rstN,
    input  logic       start,
    input  cycleKind_e kind,
    input  logic       busReq,
    input  logic       memWait,
    input  logic       waitPoint,
    input  tState_e    tState,
    input  logic       lastT,
    output cycleKind_e curKind,
    output logic       advance,
    output logic       clear,
    output logic       busAck,
    output logic       busy,
    output logic       done
);

    typedef enum logic [1:0] {
        sIdle    = 2'd0,
        sRun     = 2'd1,
        sHold    = 2'd2,
        sGranted = 2'd3
    } seqState_e;

    seqState_e state;
    seqState_e nextState;
    logic      accept;
    logic      waitTaken;
    logic      finish;

    //----------------------------------------------------------
    // Cycle control
    //----------------------------------------------------------
    // Bus request wins over a start seen at the same idle edge
    assign accept    = (state == sIdle) && start && !busReq;
    // Sampling state with WAIT high, hold the T-state one more cycle
    assign waitTaken = waitPoint && memWait;
    // Last T-state of a running cycle
    // The wait point never falls on the last T-state
    assign finish    = (state == sRun) && lastT;

    always_comb begin
        advance = 1'b0;
        unique case (state)
            sIdle:   advance = accept;
            sRun:    advance = !lastT && !waitTaken;
            // Still in the sampling state, WAIT is sampled again
            sHold:   advance = !memWait;
            default: advance = 1'b0;
        endcase
    end

    assign clear = finish;

    //----------------------------------------------------------
    // State machine
    //----------------------------------------------------------
    always_comb begin
        nextState = state;
        unique case (state)
            sIdle: begin
                if (busReq) begin
                    nextState = sGranted;
                end else if (start) begin
                    nextState = sRun;
                end
            end
            sRun: begin
                // busReq only counts at the last T-state
                if (lastT) begin
                    nextState = busReq ? sGranted : sIdle;
                end else if (waitTaken) begin
                    nextState = sHold;
                end
            end
            sHold: begin
                if (!memWait) begin
                    nextState = sRun;
                end
            end
            sGranted: begin
                // First edge with busReq low gives the bus back
                if (!busReq) begin
                    nextState = sIdle;
                end
            end
            default: nextState = sIdle;
        endcase
    end

    always_ff @(posedge setM1) begin
        if (!rstN) begin
            state   <= sIdle;
            done    <= 1'b0;
            curKind <= kFetch;
        end else begin
            state <= nextState;
            // Completion pulse in the cycle after the last T-state
            done  <= finish;
            if (accept) begin
                curKind <= kind;
            end
        end
    end

    // Busy also covers the grant so no start is taken meanwhile
    assign busy   = (state != sIdle);
    assign busAck = (state == sGranted);

endmodule

// File: verilog/padLatches.sv
//----------------------------------------------------------
// Pad latches
// Address, write and read data latches plus refresh counter
//----------------------------------------------------------
`timescale 1ns/1ps

module padLatches import busPkg::*; (
    input  logic        setM1,
    input  logic        rstN,
    input  logic        start,
    input  logic [15:0] addr,
    input  logic [7:0]  wrData,
    input  logic [7:0]  dataPins,
    input  logic        loadAddr,
    input  logic        loadRfsh,
    input  logic        captureData,
    input  cycleKind_e  curKind,
    output logic [15:0] addrPins,
    output logic [7:0]  dataOut,
    output logic [7:0]  rdData
);

    busAddr_u    addrWord;
    busAddr_u    rfshWord;
    logic [15:0] addrHold;
    logic [6:0]  rfshCount;
    logic        rfshStep;

    //----------------------------------------------------------
    // Refresh counter
    //----------------------------------------------------------
    // One step per refresh slot pair, wraps at 128
    assign rfshStep = loadRfsh && (curKind == kFetch || curKind == kIntAck);

    always_ff @(posedge setM1) begin
        if (!rstN) begin
            rfshCount <= '0;
        end else if (rfshStep) begin
            rfshCount <= rfshCount + 7'd1;
        end
    end

    always_comb begin
        rfshWord.rfshView.fill      = '0;
        rfshWord.rfshView.rfshCount = rfshCount;
    end

    //----------------------------------------------------------
    // Address and data latches
    //----------------------------------------------------------
    always_ff @(posedge setM1) begin
        // Request payload is only valid with start
        if (start) begin
            addrHold <= addr;
            dataOut  <= wrData;
        end
        // T3 keeps the old count on the word for T4
        if (loadAddr) begin
            addrWord.addr <= addrHold;
        end else if (loadRfsh) begin
            addrWord <= rfshWord;
        end
        // Last cycle of the capture state wins
        if (captureData) begin
            rdData <= dataPins;
        end
    end

    // T1 shows the held address before the word is loaded
    // T3 of a refresh slot shows the count directly
    always_comb begin
        if (loadAddr) begin
            addrPins = addrHold;
        end else if (loadRfsh) begin
            addrPins = rfshWord.addr;
        end else begin
            addrPins = addrWord.addr;
        end
    end

endmodule

// File: verilog/pinControl.sv
//----------------------------------------------------------
// Pin control
// Control pins, output enables and pad strobes per T-state
//----------------------------------------------------------
`timescale 1ns/1ps

module pinControl import busPkg::*; (
    input  logic       setM1,
    input  logic       rstN,
    input  tState_e    tState,
    input  cycleKind_e curKind,
    input  logic       busAck,
    output logic       m1,
    output logic       mreq,
    output logic       iorq,
    output logic       rd,
    output logic       wr,
    output logic       rfsh,
    output logic       ctrlOe,
    output logic       addrOe,
    output logic       dataOe,
    output logic       waitPoint,
    output logic       loadAddr,
    output logic       loadRfsh,
    output logic       captureData
);

    logic isT1;
    logic isT2;
    logic isTw1;
    logic isTw2;
    logic isT3;
    logic isT4;
    logic oeReady;

    // One-hot view of the registered T-state
    assign isT1  = (tState == tT1);
    assign isT2  = (tState == tT2);
    assign isTw1 = (tState == tTw1);
    assign isTw2 = (tState == tTw2);
    assign isT3  = (tState == tT3);
    assign isT4  = (tState == tT4);

    //----------------------------------------------------------
    // Control pins
    //----------------------------------------------------------
    // Decoded from the T-state and kind flops only
    // A held T-state keeps every pin steady
    always_comb begin
        m1     = 1'b0;
        mreq   = 1'b0;
        iorq   = 1'b0;
        rd     = 1'b0;
        wr     = 1'b0;
        rfsh   = 1'b0;
        dataOe = 1'b0;
        unique case (curKind)
            kFetch: begin
                m1   = isT1 | isT2;
                rd   = isT1 | isT2;
                // Second mreq pulse strobes the refresh address
                mreq = isT1 | isT2 | isT3 | isT4;
                rfsh = isT3 | isT4;
            end
            kMemRead: begin
                mreq = isT1 | isT2 | isT3;
                rd   = isT1 | isT2 | isT3;
            end
            kMemWrite: begin
                mreq   = isT1 | isT2 | isT3;
                // Data is on the bus a state before wr
                wr     = isT2 | isT3;
                dataOe = isT1 | isT2 | isT3;
            end
            kIoRead: begin
                iorq = isT2 | isT3 | isT4;
                rd   = isT2 | isT3 | isT4;
            end
            kIoWrite: begin
                iorq   = isT2 | isT3 | isT4;
                wr     = isT2 | isT3 | isT4;
                dataOe = isT1 | isT2 | isT3 | isT4;
            end
            kIntAck: begin
                m1   = isT1 | isT2 | isTw1 | isTw2;
                // Vector read window
                iorq = isTw1 | isTw2;
                mreq = isT3 | isT4;
                rfsh = isT3 | isT4;
            end
            default: begin
                m1 = 1'b0;
            end
        endcase
    end

    //----------------------------------------------------------
    // Strobes to the sequencer and pad latches
    //----------------------------------------------------------
    always_comb begin
        waitPoint   = 1'b0;
        captureData = 1'b0;
        unique case (curKind)
            kFetch: begin
                waitPoint   = isT2;
                captureData = isT2;
            end
            kMemRead: begin
                waitPoint   = isT2;
                captureData = isT3;
            end
            kMemWrite: waitPoint = isT2;
            kIoRead: begin
                waitPoint   = isT3;
                captureData = isT4;
            end
            kIoWrite: waitPoint = isT3;
            kIntAck: begin
                waitPoint   = isTw2;
                captureData = isTw2;
            end
            default: waitPoint = 1'b0;
        endcase
    end

    // Address pads follow the cycle address from T1
    assign loadAddr = isT1;
    // Refresh slot opens at T3 of fetch and interrupt acknowledge
    assign loadRfsh = isT3 && (curKind == kFetch || curKind == kIntAck);

    //----------------------------------------------------------
    // Output enables
    //----------------------------------------------------------
    // Low from reset until the first clean edge
    always_ff @(posedge setM1) begin
        if (!rstN) begin
            oeReady <= 1'b0;
        end else begin
            oeReady <= 1'b1;
        end
    end

    // Bus released to the requester while busAck is high
    assign ctrlOe = oeReady & ~busAck;
    assign addrOe = oeReady & ~busAck;

endmodule

// File: verilog/tStateCounter.sv
//----------------------------------------------------------
// T-state counter
// Holds the current T-state and walks each cycle kind's order
//----------------------------------------------------------
`timescale 1ns/1ps

module tStateCounter import busPkg::*; (
    input  logic       setM1,
    input  logic       rstN,
    input  logic       advance,
    input  logic       clear,
    input  cycleKind_e kind,
    output tState_e    tState,
    output logic       lastT
);

    tState_e nextT;
    tState_e lastState;

    //----------------------------------------------------------
    // Order table
    //----------------------------------------------------------
    // Memory cycles end at T3, every other kind at T4
    assign lastState = (kind == kMemRead || kind == kMemWrite) ? tT3 : tT4;
    assign lastT     = (tState == lastState);

    always_comb begin
        unique case (tState)
            // Any kind enters at T1
            tIdle:   nextT = tT1;
            tT1:     nextT = tT2;
            // Interrupt acknowledge inserts two automatic waits
            tT2:     nextT = (kind == kIntAck) ? tTw1 : tT3;
            tTw1:    nextT = tTw2;
            tTw2:    nextT = tT3;
            tT3:     nextT = (lastState == tT3) ? tIdle : tT4;
            tT4:     nextT = tIdle;
            default: nextT = tIdle;
        endcase
    end

    //----------------------------------------------------------
    // State register
    //----------------------------------------------------------
    // clear wins over advance, it ends the cycle after lastT
    always_ff @(posedge setM1) begin
        if (!rstN) begin
            tState <= tIdle;
        end else if (clear) begin
            tState <= tIdle;
        end else if (advance) begin
            tState <= nextT;
        end
    end

endmodule
